// File: common/pinmux_macros.svh
`ifndef PINMUX_MACROS_SVH
`define PINMUX_MACROS_SVH

// --------------------
// Bus widths
// --------------------
`define PM_DATA_W 32
`define PM_ADDR_W 11

// Pad and interrupt line counts
`define PM_PAD_N 16
`define PM_IRQ_N 8

// Read-only identifier returned by CHIP_ID
`define PM_CHIP_ID 32'h5049_4E01

// --------------------
// Alternate function pad positions
// --------------------
`define PM_PAD_UART_RX 0
`define PM_PAD_UART_TX 1
// PWM bit 1 sits on the next pad
`define PM_PAD_PWM0 4
// External interrupt 1 sits on the next pad
`define PM_PAD_EINT0 6

`endif

// File: common/pinmux_reg_pkg.sv
`include "pinmux_macros.svh"

package pinmux_reg_pkg;

   // Request from the bus master
   typedef struct packed {
      logic                    cs;
      logic                    wr;
      logic [`PM_ADDR_W-1:0]   addr;
      logic [`PM_DATA_W-1:0]   wdata;
      logic [`PM_DATA_W/8-1:0] be;
   } reg_req_t;

   // Response, rdata valid with ack
   typedef struct packed {
      logic [`PM_DATA_W-1:0] rdata;
      logic                  ack;
   } reg_rsp_t;

   // Block select from address bits 10:7
   typedef enum logic [3:0] {
      BLK_GLBL = 4'd0,
      BLK_GPIO = 4'd1
   } blk_sel_e;

   // Global block word index, address bits 6:2
   typedef enum logic [4:0] {
      GLBL_CHIP_ID  = 5'd0,
      GLBL_SOFT_RST = 5'd1,
      GLBL_FUNC_SEL = 5'd2,
      GLBL_IRQ_MASK = 5'd3,
      GLBL_IRQ_STAT = 5'd4,
      GLBL_SOFT_IRQ = 5'd5
   } glbl_addr_e;

   // GPIO block word index, address bits 5:2
   typedef enum logic [3:0] {
      GPIO_DIR      = 4'd0,
      GPIO_OUT      = 4'd1,
      GPIO_IN       = 4'd2,
      GPIO_INT_MASK = 4'd3,
      GPIO_INT_STAT = 4'd4
   } gpio_addr_e;

   // Expand byte enables into a bit mask
   function automatic logic [`PM_DATA_W-1:0] be_to_mask(
      input logic [`PM_DATA_W/8-1:0] be
   );
      logic [`PM_DATA_W-1:0] mask;
      for (int i = 0; i < `PM_DATA_W/8; i++) begin
         mask[8*i +: 8] = {8{be[i]}};
      end
      return mask;
   endfunction

endpackage

// File: common/pinmux_pad_pkg.sv
`include "pinmux_macros.svh"

package pinmux_pad_pkg;

   // Pad drive, oen active low
   typedef struct packed {
      logic [`PM_PAD_N-1:0] out;
      logic [`PM_PAD_N-1:0] oen;
   } pad_bus_t;

   // Alternate function enables, uart_en in bit 0
   typedef struct packed {
      logic eint_en;
      logic pwm_en;
      logic uart_en;
   } func_sel_t;

   // Interrupt sources, gpio in bit 0
   typedef struct packed {
      logic [1:0] rsvd;
      logic [2:0] timer;
      logic [1:0] eint;
      logic       gpio;
   } irq_src_t;

endpackage

// File: verilog/reg_blk_decode.sv
`timescale 1ns/1ps
`include "pinmux_macros.svh"

module reg_blk_decode (
   input  logic                     mclk,
   input  logic                     s_reset_ssn,
   input  pinmux_reg_pkg::reg_req_t reg_req_i,
   output logic                     glbl_cs_o,
   output logic                     gpio_cs_o,
   input  pinmux_reg_pkg::reg_rsp_t glbl_rsp_i,
   input  pinmux_reg_pkg::reg_rsp_t gpio_rsp_i,
   output pinmux_reg_pkg::reg_rsp_t reg_rsp_o
);
   import pinmux_reg_pkg::*;

   // Select of the current request and of the pending response
   blk_sel_e req_blk;
   blk_sel_e rsp_blk;

   // Top four address bits pick the block
   assign req_blk = blk_sel_e'(reg_req_i.addr[`PM_ADDR_W-1 -: 4]);

   assign glbl_cs_o = reg_req_i.cs && (req_blk == BLK_GLBL);
   assign gpio_cs_o = reg_req_i.cs && (req_blk == BLK_GPIO);

   // Hold the select from cs until the block answers
   always_ff @(posedge mclk or negedge s_reset_ssn) begin
      if (!s_reset_ssn) begin
         rsp_blk <= BLK_GLBL;
      end else if (reg_req_i.cs) begin
         rsp_blk <= req_blk;
      end
   end

   // Response mux, unmapped blocks read as zero with no ack
   always_comb begin
      case (rsp_blk)
         BLK_GLBL: reg_rsp_o = glbl_rsp_i;
         BLK_GPIO: reg_rsp_o = gpio_rsp_i;
         default:  reg_rsp_o = '0;
      endcase
   end

endmodule

// File: glbl_reg/glbl_reg.sv
`timescale 1ns/1ps
`include "pinmux_macros.svh"

module glbl_reg (
   input  logic                      mclk,
   input  logic                      s_reset_ssn,
   input  logic                      cs_i,
   input  pinmux_reg_pkg::reg_req_t  reg_req_i,
   output pinmux_reg_pkg::reg_rsp_t  reg_rsp_o,
   input  pinmux_pad_pkg::irq_src_t  irq_src_i,
   output pinmux_pad_pkg::func_sel_t func_sel_o,
   output logic [1:0]                uart_rst_o,
   output logic                      soft_irq_o,
   output logic [`PM_IRQ_N-1:0]      irq_lines_o
);
   import pinmux_reg_pkg::*;
   import pinmux_pad_pkg::*;

   glbl_addr_e            reg_idx;
   logic                  wr_en;
   logic [`PM_DATA_W-1:0] wmask;
   logic [`PM_DATA_W-1:0] rdata_d;
   // Control registers
   logic [1:0]            soft_rst_q;
   func_sel_t             func_sel_q;
   logic [`PM_IRQ_N-1:0]  irq_mask_q;
   logic [`PM_IRQ_N-1:0]  irq_stat_q;
   logic                  soft_irq_q;
   logic [`PM_IRQ_N-1:0]  irq_clr;

   assign reg_idx = glbl_addr_e'(reg_req_i.addr[6:2]);
   assign wr_en   = cs_i && reg_req_i.wr;
   assign wmask   = be_to_mask(reg_req_i.be);

   // Write-one-to-clear on status, limited to enabled bytes
   assign irq_clr = (wr_en && reg_idx == GLBL_IRQ_STAT) ?
                    (reg_req_i.wdata[`PM_IRQ_N-1:0] & wmask[`PM_IRQ_N-1:0]) : '0;

   // --------------------
   // Register writes
   // --------------------
   always_ff @(posedge mclk or negedge s_reset_ssn) begin
      if (!s_reset_ssn) begin
         soft_rst_q <= '0;
         func_sel_q <= '0;
         irq_mask_q <= '0;
         irq_stat_q <= '0;
         soft_irq_q <= 1'b0;
      end else begin
         if (wr_en && reg_idx == GLBL_SOFT_RST) begin
            soft_rst_q <= (soft_rst_q & ~wmask[1:0]) | (reg_req_i.wdata[1:0] & wmask[1:0]);
         end
         if (wr_en && reg_idx == GLBL_FUNC_SEL) begin
            func_sel_q <= (func_sel_q & ~wmask[2:0]) | (reg_req_i.wdata[2:0] & wmask[2:0]);
         end
         if (wr_en && reg_idx == GLBL_IRQ_MASK) begin
            irq_mask_q <= (irq_mask_q & ~wmask[`PM_IRQ_N-1:0]) |
                          (reg_req_i.wdata[`PM_IRQ_N-1:0] & wmask[`PM_IRQ_N-1:0]);
         end
         if (wr_en && reg_idx == GLBL_SOFT_IRQ && reg_req_i.be[0]) begin
            soft_irq_q <= reg_req_i.wdata[0];
         end
         // Sticky status, a live source wins over the clear
         irq_stat_q <= (irq_stat_q & ~irq_clr) | irq_src_i;
      end
   end

   // Read mux
   always_comb begin
      rdata_d = '0;
      case (reg_idx)
         GLBL_CHIP_ID:  rdata_d = `PM_CHIP_ID;
         GLBL_SOFT_RST: rdata_d[1:0] = soft_rst_q;
         GLBL_FUNC_SEL: rdata_d[2:0] = func_sel_q;
         GLBL_IRQ_MASK: rdata_d[`PM_IRQ_N-1:0] = irq_mask_q;
         GLBL_IRQ_STAT: rdata_d[`PM_IRQ_N-1:0] = irq_stat_q;
         GLBL_SOFT_IRQ: rdata_d[0] = soft_irq_q;
         default:       rdata_d = '0;
      endcase
   end

   // Ack one cycle after cs, read data captured with it
   always_ff @(posedge mclk or negedge s_reset_ssn) begin
      if (!s_reset_ssn) begin
         reg_rsp_o <= '0;
      end else begin
         reg_rsp_o.ack <= cs_i;
         if (cs_i) begin
            reg_rsp_o.rdata <= rdata_d;
         end
      end
   end

   // Outputs, uart resets stay low until software releases them
   assign func_sel_o  = func_sel_q;
   assign uart_rst_o  = soft_rst_q;
   assign soft_irq_o  = soft_irq_q;
   assign irq_lines_o = irq_stat_q & irq_mask_q;

endmodule

// File: gpio/gpio_reg.sv
`timescale 1ns/1ps
`include "pinmux_macros.svh"

module gpio_reg (
   input  logic                     mclk,
   input  logic                     s_reset_ssn,
   input  logic                     cs_i,
   input  pinmux_reg_pkg::reg_req_t reg_req_i,
   output pinmux_reg_pkg::reg_rsp_t reg_rsp_o,
   input  logic [`PM_PAD_N-1:0]     pad_gpio_i,
   output logic [`PM_PAD_N-1:0]     gpio_dir_o,
   output logic [`PM_PAD_N-1:0]     gpio_out_o,
   output logic                     gpio_intr_o
);
   import pinmux_reg_pkg::*;

   gpio_addr_e            reg_idx;
   logic                  wr_en;
   logic [`PM_DATA_W-1:0] wmask;
   logic [`PM_PAD_N-1:0]  bmask;
   logic [`PM_PAD_N-1:0]  wdata;
   logic [`PM_DATA_W-1:0] rdata_d;
   // Configuration and status
   logic [`PM_PAD_N-1:0]  dir_q;
   logic [`PM_PAD_N-1:0]  out_q;
   logic [`PM_PAD_N-1:0]  int_mask_q;
   logic [`PM_PAD_N-1:0]  int_stat_q;
   logic [`PM_PAD_N-1:0]  int_clr;
   // Synchronizer stages and edge history
   logic [`PM_PAD_N-1:0]  sync1_q;
   logic [`PM_PAD_N-1:0]  sync2_q;
   logic [`PM_PAD_N-1:0]  sync3_q;
   logic [`PM_PAD_N-1:0]  rise;

   assign reg_idx = gpio_addr_e'(reg_req_i.addr[5:2]);
   assign wr_en   = cs_i && reg_req_i.wr;
   assign wmask   = be_to_mask(reg_req_i.be);
   // Only the low half word is implemented
   assign bmask   = wmask[`PM_PAD_N-1:0];
   assign wdata   = reg_req_i.wdata[`PM_PAD_N-1:0];

   assign rise    = sync2_q & ~sync3_q;
   assign int_clr = (wr_en && reg_idx == GPIO_INT_STAT) ? (wdata & bmask) : '0;

   // --------------------
   // Input synchronizer
   // --------------------
   always_ff @(posedge mclk or negedge s_reset_ssn) begin
      if (!s_reset_ssn) begin
         sync1_q <= '0;
         sync2_q <= '0;
         sync3_q <= '0;
      end else begin
         sync1_q <= pad_gpio_i;
         sync2_q <= sync1_q;
         sync3_q <= sync2_q;
      end
   end

   // Register writes, edge sets beat a same-cycle clear
   always_ff @(posedge mclk or negedge s_reset_ssn) begin
      if (!s_reset_ssn) begin
         dir_q      <= '0;
         out_q      <= '0;
         int_mask_q <= '0;
         int_stat_q <= '0;
      end else begin
         if (wr_en && reg_idx == GPIO_DIR)      dir_q <= (dir_q & ~bmask) | (wdata & bmask);
         if (wr_en && reg_idx == GPIO_OUT)      out_q <= (out_q & ~bmask) | (wdata & bmask);
         if (wr_en && reg_idx == GPIO_INT_MASK) begin
            int_mask_q <= (int_mask_q & ~bmask) | (wdata & bmask);
         end
         int_stat_q <= (int_stat_q & ~int_clr) | rise;
      end
   end

   // Read mux
   always_comb begin
      rdata_d = '0;
      case (reg_idx)
         GPIO_DIR:      rdata_d[`PM_PAD_N-1:0] = dir_q;
         GPIO_OUT:      rdata_d[`PM_PAD_N-1:0] = out_q;
         GPIO_IN:       rdata_d[`PM_PAD_N-1:0] = sync2_q;
         GPIO_INT_MASK: rdata_d[`PM_PAD_N-1:0] = int_mask_q;
         GPIO_INT_STAT: rdata_d[`PM_PAD_N-1:0] = int_stat_q;
         default:       rdata_d = '0;
      endcase
   end

   always_ff @(posedge mclk or negedge s_reset_ssn) begin
      if (!s_reset_ssn) begin
         reg_rsp_o <= '0;
      end else begin
         reg_rsp_o.ack <= cs_i;
         if (cs_i) reg_rsp_o.rdata <= rdata_d;
      end
   end

   assign gpio_dir_o  = dir_q;
   assign gpio_out_o  = out_q;
   // Any masked pending edge
   assign gpio_intr_o = |(int_stat_q & int_mask_q);

endmodule

// File: verilog/pad_mux.sv
`timescale 1ns/1ps
`include "pinmux_macros.svh"

module pad_mux (
   input  pinmux_pad_pkg::func_sel_t func_sel_i,
   input  logic [`PM_PAD_N-1:0]      gpio_dir_i,
   input  logic [`PM_PAD_N-1:0]      gpio_out_i,
   input  logic                      uart_txd_i,
   output logic                      uart_rxd_o,
   input  logic [1:0]                pwm_wfm_i,
   input  logic [`PM_PAD_N-1:0]      pad_in_i,
   output pinmux_pad_pkg::pad_bus_t  pad_o,
   output logic [`PM_PAD_N-1:0]      pad_gpio_o,
   output logic [1:0]                eint_o
);

   always_comb begin
      // GPIO owns every pad by default, dir 1 means output
      pad_o.out  = gpio_out_i;
      pad_o.oen  = ~gpio_dir_i;
      // Idle line for UART, no external interrupt
      uart_rxd_o = 1'b1;
      eint_o     = 2'b00;
      if (func_sel_i.uart_en) begin
         pad_o.oen[`PM_PAD_UART_RX] = 1'b1;
         pad_o.out[`PM_PAD_UART_RX] = 1'b0;
         uart_rxd_o                 = pad_in_i[`PM_PAD_UART_RX];
         pad_o.oen[`PM_PAD_UART_TX] = 1'b0;
         pad_o.out[`PM_PAD_UART_TX] = uart_txd_i;
      end
      if (func_sel_i.pwm_en) begin
         pad_o.oen[`PM_PAD_PWM0 +: 2] = 2'b00;
         pad_o.out[`PM_PAD_PWM0 +: 2] = pwm_wfm_i;
      end
      // Level interrupts, pads held as inputs
      if (func_sel_i.eint_en) begin
         pad_o.oen[`PM_PAD_EINT0 +: 2] = 2'b11;
         pad_o.out[`PM_PAD_EINT0 +: 2] = 2'b00;
         eint_o                        = pad_in_i[`PM_PAD_EINT0 +: 2];
      end
   end

   // GPIO sees the raw pad levels
   assign pad_gpio_o = pad_in_i;

endmodule

// File: verilog/pinmux_top.sv
`timescale 1ns/1ps
`include "pinmux_macros.svh"

module pinmux_top (
   input  logic                     mclk,
   input  logic                     s_reset_ssn,
   input  pinmux_reg_pkg::reg_req_t reg_req_i,
   output pinmux_reg_pkg::reg_rsp_t reg_rsp_o,
   input  logic [`PM_PAD_N-1:0]     pad_in_i,
   output pinmux_pad_pkg::pad_bus_t pad_o,
   input  logic                     uart_txd_i,
   output logic                     uart_rxd_o,
   input  logic [1:0]               pwm_wfm_i,
   input  logic [2:0]               timer_intr_i,
   output logic [1:0]               uart_rst_o,
   output logic                     soft_irq_o,
   output logic [`PM_IRQ_N-1:0]     irq_lines_o
);
   import pinmux_reg_pkg::*;
   import pinmux_pad_pkg::*;

   // Per-block strobes and responses
   logic                 glbl_cs;
   logic                 gpio_cs;
   reg_rsp_t             glbl_rsp;
   reg_rsp_t             gpio_rsp;
   // Pad side
   func_sel_t            func_sel;
   logic [`PM_PAD_N-1:0] gpio_dir;
   logic [`PM_PAD_N-1:0] gpio_out;
   logic [`PM_PAD_N-1:0] pad_gpio;
   logic [1:0]           eint;
   logic                 gpio_intr;
   irq_src_t             irq_src;

   // Interrupt source vector, reserved bits tied low
   assign irq_src = '{rsvd: 2'b00, timer: timer_intr_i, eint: eint, gpio: gpio_intr};

   // --------------------
   // Register access
   // --------------------
   reg_blk_decode u_reg_blk_decode (
      .mclk        (mclk),
      .s_reset_ssn (s_reset_ssn),
      .reg_req_i   (reg_req_i),
      .glbl_cs_o   (glbl_cs),
      .gpio_cs_o   (gpio_cs),
      .glbl_rsp_i  (glbl_rsp),
      .gpio_rsp_i  (gpio_rsp),
      .reg_rsp_o   (reg_rsp_o)
   );

   glbl_reg u_glbl_reg (
      .mclk        (mclk),
      .s_reset_ssn (s_reset_ssn),
      .cs_i        (glbl_cs),
      .reg_req_i   (reg_req_i),
      .reg_rsp_o   (glbl_rsp),
      .irq_src_i   (irq_src),
      .func_sel_o  (func_sel),
      .uart_rst_o  (uart_rst_o),
      .soft_irq_o  (soft_irq_o),
      .irq_lines_o (irq_lines_o)
   );

   gpio_reg u_gpio_reg (
      .mclk        (mclk),
      .s_reset_ssn (s_reset_ssn),
      .cs_i        (gpio_cs),
      .reg_req_i   (reg_req_i),
      .reg_rsp_o   (gpio_rsp),
      .pad_gpio_i  (pad_gpio),
      .gpio_dir_o  (gpio_dir),
      .gpio_out_o  (gpio_out),
      .gpio_intr_o (gpio_intr)
   );

   // --------------------
   // Pads
   // --------------------
   pad_mux u_pad_mux (
      .func_sel_i  (func_sel),
      .gpio_dir_i  (gpio_dir),
      .gpio_out_i  (gpio_out),
      .uart_txd_i  (uart_txd_i),
      .uart_rxd_o  (uart_rxd_o),
      .pwm_wfm_i   (pwm_wfm_i),
      .pad_in_i    (pad_in_i),
      .pad_o       (pad_o),
      .pad_gpio_o  (pad_gpio),
      .eint_o      (eint)
   );

endmodule

// File: tests/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
   output logic mclk,
   output logic s_reset_ssn
);

   // 100 ns period
   initial begin
      mclk = 1'b0;
      forever #50 mclk = ~mclk;
   end

   // Reset held low for the first 8 rising edges
   initial begin
      s_reset_ssn = 1'b0;
      repeat (8) @(posedge mclk);
      s_reset_ssn <= 1'b1;
   end

endmodule

// File: tests/pinmux_asserts.sv
`timescale 1ns/1ps

module pinmux_asserts (
   input logic                     mclk,
   input logic                     s_reset_ssn,
   input pinmux_reg_pkg::reg_req_t reg_req_i,
   input pinmux_reg_pkg::reg_rsp_t reg_rsp_i,
   input pinmux_pad_pkg::pad_bus_t pad_i
);

   // --------------------
   // Bus timing
   // --------------------
   // Ack only in the cycle right after a strobe
   ack_follows_cs: assert property (
      @(posedge mclk) disable iff (!s_reset_ssn) reg_rsp_i.ack |-> $past(reg_req_i.cs)
   ) else $error("ack seen without a strobe in the previous cycle");

   // Single-cycle ack
   ack_single: assert property (
      @(posedge mclk) disable iff (!s_reset_ssn) reg_rsp_i.ack |=> !reg_rsp_i.ack
   ) else $error("ack high for two cycles in a row");

   // --------------------
   // Pads
   // --------------------
   // Every pad an input while reset is low
   oen_in_reset: assert property (
      @(posedge mclk) !s_reset_ssn |-> (pad_i.oen == '1)
   ) else $error("pad driven during reset");

endmodule

// Attached to the top level
bind pinmux_top pinmux_asserts u_pinmux_asserts (
   .mclk        (mclk),
   .s_reset_ssn (s_reset_ssn),
   .reg_req_i   (reg_req_i),
   .reg_rsp_i   (reg_rsp_o),
   .pad_i       (pad_o)
);

// File: tests/pinmux_tb.sv
`timescale 1ns/1ps
`include "pinmux_macros.svh"

module pinmux_tb;
   import pinmux_reg_pkg::*;
   import pinmux_pad_pkg::*;

   // Six tests of at most 60 accesses, about 5 cycles each, plus margin
   localparam int TEST_N      = 6;
   localparam int ACC_MAX     = 60;
   localparam int ACC_CYC     = 5;
   localparam int CYCLE_LIMIT = TEST_N * ACC_MAX * ACC_CYC + 200;

   // Expected response of one access
   typedef struct packed {
      logic        chk;
      logic [10:0] addr;
      logic [31:0] val;
   } exp_t;

   logic                 mclk;
   logic                 s_reset_ssn;
   reg_req_t             req;
   reg_rsp_t             rsp;
   logic [`PM_PAD_N-1:0] pad_in;
   pad_bus_t             pads;
   logic                 uart_txd;
   logic                 uart_rxd;
   logic [1:0]           pwm_wfm;
   logic [2:0]           timer_intr;
   logic [1:0]           uart_rst;
   logic                 soft_irq;
   logic [`PM_IRQ_N-1:0] irq_lines;

   // Shadow registers of the reference model
   logic [31:0] sh_soft_rst = '0;
   logic [31:0] sh_func_sel = '0;
   logic [31:0] sh_irq_mask = '0;
   logic [31:0] sh_irq_stat = '0;
   logic [31:0] sh_soft_irq = '0;
   logic [31:0] sh_dir      = '0;
   logic [31:0] sh_out      = '0;
   logic [31:0] sh_int_mask = '0;
   logic [31:0] sh_int_stat = '0;
   // Last level driven on the pads
   logic [31:0] sh_pad      = '0;

   int          err_cnt   = 0;
   int          chk_cnt   = 0;
   int          test_cnt  = 0;
   int          test_err0 = 0;
   int          cycle_cnt = 0;
   logic [31:0] lcg_state;
   exp_t        exp_q[$];

   tb_clk_gen u_tb_clk_gen (
      .mclk        (mclk),
      .s_reset_ssn (s_reset_ssn)
   );

   pinmux_top u_pinmux_top (
      .mclk         (mclk),
      .s_reset_ssn  (s_reset_ssn),
      .reg_req_i    (req),
      .reg_rsp_o    (rsp),
      .pad_in_i     (pad_in),
      .pad_o        (pads),
      .uart_txd_i   (uart_txd),
      .uart_rxd_o   (uart_rxd),
      .pwm_wfm_i    (pwm_wfm),
      .timer_intr_i (timer_intr),
      .uart_rst_o   (uart_rst),
      .soft_irq_o   (soft_irq),
      .irq_lines_o  (irq_lines)
   );

   // --------------------
   // Helpers
   // --------------------
   // LCG step, numerical recipes constants
   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Byte lanes with be set take the new data
   function automatic logic [31:0] byte_merge(input logic [31:0] old, input logic [31:0] wd,
                                              input logic [3:0] be);
      logic [31:0] res;
      res = old;
      for (int b = 0; b < 4; b++) begin
         if (be[b]) res[8*b +: 8] = wd[8*b +: 8];
      end
      return res;
   endfunction

   function automatic logic [10:0] glbl_addr(input glbl_addr_e idx);
      return {BLK_GLBL, idx, 2'b00};
   endfunction

   function automatic logic [10:0] gpio_addr(input gpio_addr_e idx);
      return {BLK_GPIO, 1'b0, idx, 2'b00};
   endfunction

   // Reference model, expected read data from the shadows
   function automatic logic [31:0] ref_read(input logic [10:0] addr);
      logic [31:0] d;
      d = 32'h0;
      if (addr[10:7] == BLK_GLBL) begin
         case (addr[6:2])
            GLBL_CHIP_ID:  d = `PM_CHIP_ID;
            GLBL_SOFT_RST: d = sh_soft_rst;
            GLBL_FUNC_SEL: d = sh_func_sel;
            GLBL_IRQ_MASK: d = sh_irq_mask;
            GLBL_IRQ_STAT: d = sh_irq_stat;
            GLBL_SOFT_IRQ: d = sh_soft_irq;
            default:       d = 32'h0;
         endcase
      end else if (addr[10:7] == BLK_GPIO) begin
         case (addr[5:2])
            GPIO_DIR:      d = sh_dir;
            GPIO_OUT:      d = sh_out;
            GPIO_IN:       d = sh_pad;
            GPIO_INT_MASK: d = sh_int_mask;
            GPIO_INT_STAT: d = sh_int_stat;
            default:       d = 32'h0;
         endcase
      end
      return d;
   endfunction

   // Shadow update, status registers clear on ones
   task automatic apply_write(input logic [10:0] addr, input logic [31:0] d,
                              input logic [3:0] be);
      logic [31:0] m;
      m = byte_merge(32'h0, 32'hFFFF_FFFF, be);
      if (addr[10:7] == BLK_GLBL) begin
         case (addr[6:2])
            GLBL_SOFT_RST: sh_soft_rst = byte_merge(sh_soft_rst, d, be) & 32'h3;
            GLBL_FUNC_SEL: sh_func_sel = byte_merge(sh_func_sel, d, be) & 32'h7;
            GLBL_IRQ_MASK: sh_irq_mask = byte_merge(sh_irq_mask, d, be) & 32'hFF;
            GLBL_IRQ_STAT: sh_irq_stat = sh_irq_stat & ~(d & m);
            GLBL_SOFT_IRQ: sh_soft_irq = byte_merge(sh_soft_irq, d, be) & 32'h1;
            default: ;
         endcase
      end else if (addr[10:7] == BLK_GPIO) begin
         case (addr[5:2])
            GPIO_DIR:      sh_dir      = byte_merge(sh_dir, d, be) & 32'hFFFF;
            GPIO_OUT:      sh_out      = byte_merge(sh_out, d, be) & 32'hFFFF;
            GPIO_INT_MASK: sh_int_mask = byte_merge(sh_int_mask, d, be) & 32'hFFFF;
            GPIO_INT_STAT: sh_int_stat = sh_int_stat & ~(d & m & 32'hFFFF);
            default: ;
         endcase
      end
   endtask

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      chk_cnt++;
      assert (got === exp) else begin
         $display("FAILED %s: got %h, expected %h", name, got, exp);
         err_cnt++;
      end
   endtask

   // One access, strobe for a cycle, then wait up to 4 cycles for ack
   task automatic bus_access(input logic wr, input logic [10:0] addr, input logic [31:0] wdata,
                             input logic [3:0] be, input logic chk);
      exp_t e;
      int   lat;
      logic seen;
      logic mapped;
      mapped = (addr[10:7] == BLK_GLBL) || (addr[10:7] == BLK_GPIO);
      e.chk  = chk;
      e.addr = addr;
      e.val  = ref_read(addr);
      if (mapped) exp_q.push_back(e);
      @(posedge mclk);
      req <= '{cs: 1'b1, wr: wr, addr: addr, wdata: wdata, be: be};
      @(posedge mclk);
      req.cs <= 1'b0;
      lat  = 0;
      seen = 1'b0;
      while (!seen && lat < 4) begin
         @(negedge mclk);
         lat++;
         seen = rsp.ack;
      end
      chk_cnt++;
      if (mapped) begin
         assert (seen && lat == 1) else begin
            $display("No ack one cycle after cs for address %h", addr);
            err_cnt++;
         end
      end else begin
         assert (!seen && rsp.rdata == 32'h0) else begin
            $display("Unmapped address %h answered with ack or data", addr);
            err_cnt++;
         end
      end
   endtask

   task automatic reg_write(input logic [10:0] addr, input logic [31:0] d, input logic [3:0] be);
      bus_access(1'b1, addr, d, be, 1'b0);
      apply_write(addr, d, be);
   endtask

   task automatic reg_read(input logic [10:0] addr);
      bus_access(1'b0, addr, 32'h0, 4'hF, 1'b1);
   endtask

   // New pad level, held long enough to pass the synchronizer
   task automatic drive_pads(input logic [15:0] v);
      @(posedge mclk);
      pad_in <= v;
      // Rising edges latch into the GPIO status
      sh_int_stat = sh_int_stat | {16'h0, v & ~sh_pad[15:0]};
      sh_pad      = {16'h0, v};
      repeat (3) @(posedge mclk);
   endtask

   task automatic end_test(input string name);
      @(posedge mclk);
      test_cnt++;
      $display("Test %0d (%s) finished with %0d errors", test_cnt, name, err_cnt - test_err0);
      test_err0 = err_cnt;
   endtask

   // --------------------
   // Response compare
   // --------------------
   always @(negedge mclk) begin
      exp_t e;
      if (s_reset_ssn && rsp.ack) begin
         assert (exp_q.size() != 0) else begin
            $display("Ack seen with no access outstanding");
            err_cnt++;
         end
         if (exp_q.size() != 0) begin
            e = exp_q.pop_front();
            if (e.chk) begin
               chk_cnt++;
               assert (rsp.rdata === e.val) else begin
                  $display("FAILED reg_rsp_o.rdata at %h: got %h, expected %h",
                           e.addr, rsp.rdata, e.val);
                  err_cnt++;
               end
            end
         end
      end
   end

   // Run limit
   always @(posedge mclk) begin
      cycle_cnt++;
      if (cycle_cnt > CYCLE_LIMIT) begin
         $display("Run stopped after %0d cycles without finishing", CYCLE_LIMIT);
         $display("Something failed");
         $finish;
      end
   end

   // --------------------
   // Stimulus
   // --------------------
   initial begin
      logic [31:0] r;
      logic [31:0] d;
      logic [15:0] pv;
      logic [2:0]  t;
      logic [10:0] targets [6];
      lcg_state  = 32'h0471_f33c;
      req        = '0;
      pad_in     = '0;
      uart_txd   = 1'b1;
      pwm_wfm    = 2'b00;
      timer_intr = 3'b000;
      targets[0] = glbl_addr(GLBL_SOFT_RST);
      targets[1] = glbl_addr(GLBL_FUNC_SEL);
      targets[2] = glbl_addr(GLBL_IRQ_MASK);
      targets[3] = glbl_addr(GLBL_SOFT_IRQ);
      targets[4] = gpio_addr(GPIO_DIR);
      targets[5] = gpio_addr(GPIO_OUT);
      @(posedge s_reset_ssn);
      @(negedge mclk);

      // Reset values, chip id, unmapped block
      check_val("pad_o.oen", 32'(pads.oen), 32'h0000_FFFF);
      check_val("pad_o.out", 32'(pads.out), 32'h0);
      check_val("uart_rst_o", 32'(uart_rst), 32'h0);
      check_val("soft_irq_o", 32'(soft_irq), 32'h0);
      check_val("irq_lines_o", 32'(irq_lines), 32'h0);
      check_val("reg_rsp_o.ack", 32'(rsp.ack), 32'h0);
      reg_read(glbl_addr(GLBL_CHIP_ID));
      bus_access(1'b0, {4'd5, 7'd0}, 32'h0, 4'hF, 1'b0);
      end_test("chip id and unmapped block");

      // Random byte-enabled writes, read back
      for (int i = 0; i < 24; i++) begin
         d = next_rand();
         r = next_rand();
         reg_write(targets[i % 6], d, r[3:0]);
         reg_read(targets[i % 6]);
         check_val("uart_rst_o", 32'(uart_rst), sh_soft_rst);
         check_val("soft_irq_o", 32'(soft_irq), sh_soft_irq);
      end
      end_test("register write and read back");

      // GPIO owns all pads
      reg_write(glbl_addr(GLBL_FUNC_SEL), 32'h0, 4'hF);
      @(negedge mclk);
      check_val("pad_o.out", 32'(pads.out), sh_out);
      check_val("pad_o.oen", 32'(pads.oen), {16'h0, ~sh_dir[15:0]});
      for (int i = 0; i < 4; i++) begin
         r = next_rand();
         drive_pads(r[15:0]);
         reg_read(gpio_addr(GPIO_IN));
      end
      end_test("gpio pads and input sync");

      // Edge interrupt through both status registers
      drive_pads(16'h0);
      reg_write(gpio_addr(GPIO_INT_STAT), 32'hFFFF, 4'hF);
      reg_write(glbl_addr(GLBL_IRQ_STAT), 32'hFF, 4'hF);
      r  = next_rand();
      pv = 16'h1 << r[3:0];
      drive_pads(pv);
      reg_read(gpio_addr(GPIO_INT_STAT));
      reg_write(gpio_addr(GPIO_INT_MASK), {16'h0, pv}, 4'h3);
      // GPIO line latches into global status bit 0
      sh_irq_stat = sh_irq_stat | 32'h1;
      reg_write(glbl_addr(GLBL_IRQ_MASK), 32'h1, 4'hF);
      check_val("irq_lines_o", 32'(irq_lines), sh_irq_stat & sh_irq_mask);
      reg_read(glbl_addr(GLBL_IRQ_STAT));
      reg_write(gpio_addr(GPIO_INT_STAT), {16'h0, pv}, 4'h3);
      reg_write(glbl_addr(GLBL_IRQ_STAT), 32'h1, 4'h1);
      reg_read(gpio_addr(GPIO_INT_STAT));
      reg_read(glbl_addr(GLBL_IRQ_STAT));
      check_val("irq_lines_o", 32'(irq_lines), 32'h0);
      reg_write(gpio_addr(GPIO_INT_MASK), 32'h0, 4'hF);
      end_test("gpio edge interrupt");

      // All alternate functions on
      reg_write(glbl_addr(GLBL_FUNC_SEL), 32'h7, 4'h1);
      for (int i = 0; i < 4; i++) begin
         r = next_rand();
         @(posedge mclk);
         uart_txd <= r[0];
         pwm_wfm  <= r[2:1];
         drive_pads({15'h0, r[3]});
         @(negedge mclk);
         // Pads 1, 4 and 5 driven by the functions
         check_val("pad_o.out", 32'(pads.out & 16'h0032),
                   {16'h0, 10'h0, r[2:1], 2'b00, r[0], 1'b0});
         check_val("pad_o.oen", 32'(pads.oen & 16'h00F3), 32'h0000_00C1);
         check_val("uart_rxd_o", 32'(uart_rxd), {31'h0, r[3]});
      end
      drive_pads(16'h0040);
      sh_irq_stat = sh_irq_stat | 32'h2;
      reg_read(glbl_addr(GLBL_IRQ_STAT));
      drive_pads(16'h0080);
      sh_irq_stat = sh_irq_stat | 32'h4;
      reg_read(glbl_addr(GLBL_IRQ_STAT));
      drive_pads(16'h0000);
      reg_write(glbl_addr(GLBL_IRQ_STAT), 32'h6, 4'h1);
      reg_read(glbl_addr(GLBL_IRQ_STAT));
      end_test("alternate functions");

      // Timer pulse, sticky until cleared
      r = next_rand();
      t = r[2:0] | 3'b001;
      @(posedge mclk);
      timer_intr <= t;
      @(posedge mclk);
      timer_intr <= 3'b000;
      sh_irq_stat = sh_irq_stat | {26'h0, t, 3'b000};
      repeat (2) @(posedge mclk);
      reg_read(glbl_addr(GLBL_IRQ_STAT));
      reg_write(glbl_addr(GLBL_IRQ_MASK), 32'h38, 4'h1);
      check_val("irq_lines_o", 32'(irq_lines), sh_irq_stat & sh_irq_mask);
      reg_write(glbl_addr(GLBL_IRQ_STAT), 32'h38, 4'h1);
      reg_read(glbl_addr(GLBL_IRQ_STAT));
      check_val("irq_lines_o", 32'(irq_lines), 32'h0);
      end_test("timer interrupts");

      $display("Tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// File: filelist.f
+incdir+common
common/pinmux_reg_pkg.sv
common/pinmux_pad_pkg.sv
verilog/reg_blk_decode.sv
glbl_reg/glbl_reg.sv
gpio/gpio_reg.sv
verilog/pad_mux.sv
verilog/pinmux_top.sv
tests/tb_clk_gen.sv
tests/pinmux_asserts.sv
tests/pinmux_tb.sv

// File: run_sim.sh
#!/bin/bash
# Build and run the pin mux testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f filelist.f --top-module pinmux_tb -o pinmux_sim
./obj_dir/pinmux_sim | tee sim.log
if grep -q "^Everything OK$" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi
